/* common/fma_special_macros.svh */
/*
 * binary16 FMA special-value constants
 * field widths, special encodings and the widths of the mode and select codes
 */

`ifndef FMA_SPECIAL_MACROS_SVH
`define FMA_SPECIAL_MACROS_SVH

//////////////////////////////////////////////////////////////////////////////
// binary16 field layout
//////////////////////////////////////////////////////////////////////////////

// one sign bit, a 5-bit biased exponent and a 10-bit fraction
`define FP16_W          16
`define EXP_W           5
`define FRAC_W          10

// an all-ones exponent marks an infinity or a NaN
`define EXP_ALL_ONES    5'd31

//////////////////////////////////////////////////////////////////////////////
// special encodings
//////////////////////////////////////////////////////////////////////////////

// canonical quiet NaN, positive sign with only the quiet bit set in the fraction
`define FP16_QNAN       16'h7E00
`define FP16_POS_INF    16'h7C00
`define FP16_NEG_INF    16'hFC00
`define FP16_POS_ZERO   16'h0000
`define FP16_NEG_ZERO   16'h8000

// width of the rounding-mode code and of the resolver's select code
`define RM_W            2
`define SEL_W           3

`endif

/* common/fma_special_pkg.sv */
/*
 * FMA special-value package
 * binary16 operand types, rounding modes and the resolver's result choices
 */

`include "fma_special_macros.svh"

package fma_special_pkg;

    // a full binary16 word and its two packed fields
    typedef logic [`FP16_W-1:0] fp16_t;
    typedef logic [`EXP_W-1:0]  fp16_exp_t;
    typedef logic [`FRAC_W-1:0] fp16_frac_t;

    // rounding-mode encoding as seen on the FMA boundary
    // only round-down flips the sign of an exact zero sum of opposite-signed addends
    typedef enum logic [`RM_W-1:0]
    {
        rm_nearest = 2'b00,
        rm_zero    = 2'b01,
        rm_down    = 2'b10,
        rm_up      = 2'b11
    } round_mode_t;

    // source of the final result
    // sel_rounded and sel_z are ordinary arithmetic outcomes, the rest are
    // fixed special encodings that override the datapath
    typedef enum logic [`SEL_W-1:0]
    {
        sel_rounded  = 3'd0,
        sel_z        = 3'd1,
        sel_qnan     = 3'd2,
        sel_pos_inf  = 3'd3,
        sel_neg_inf  = 3'd4,
        sel_pos_zero = 3'd5,
        sel_neg_zero = 3'd6
    } special_sel_t;

endpackage

/* common/fp_class_if.sv */
/*
 * operand classification bundle
 * NaN, signalling-NaN, infinity, zero and sign flags for x, y and z
 */

`timescale 1ns/100ps

interface fp_class_if;

    // one group of five flags per operand
    logic x_nan, x_snan, x_inf, x_zero, x_sign;
    logic y_nan, y_snan, y_inf, y_zero, y_sign;
    logic z_nan, z_snan, z_inf, z_zero, z_sign;

    // the classifier drives every flag
    modport src
    (
        output x_nan, x_snan, x_inf, x_zero, x_sign,
        output y_nan, y_snan, y_inf, y_zero, y_sign,
        output z_nan, z_snan, z_inf, z_zero, z_sign
    );

    // the resolver only reads them
    // flags are combinational, valid as long as the operands are stable
    modport dst
    (
        input x_nan, x_snan, x_inf, x_zero, x_sign,
        input y_nan, y_snan, y_inf, y_zero, y_sign,
        input z_nan, z_snan, z_inf, z_zero, z_sign
    );

endinterface

/* special_case/operand_classifier.sv */
/*
 * operand classifier
 * decodes the three binary16 FMA operands into special-value flags
 */

`timescale 1ns/100ps

`include "fma_special_macros.svh"

module operand_classifier
(
    input  fma_special_pkg::fp16_t x,
    input  fma_special_pkg::fp16_t y,
    input  fma_special_pkg::fp16_t z,
    fp_class_if.src                cls
);

    import fma_special_pkg::*;

    //////////////////////////////////////////////////////////////////////////
    // per-operand decode
    //////////////////////////////////////////////////////////////////////////

    // returns the flags packed as {nan, snan, inf, zero, sign}
    // the same decode serves all three operands
    function automatic logic [4:0] classify(input fp16_t op);
        fp16_exp_t  exp_f;
        fp16_frac_t frac_f;
        logic       exp_max;
        logic       frac_nz;
        logic       is_nan;
        logic       is_snan;
        logic       is_inf;
        logic       is_zero;

        // exponent sits just below the sign, fraction in the low bits
        exp_f  = op[`FP16_W-2 -: `EXP_W];
        frac_f = op[`FRAC_W-1:0];

        exp_max = (exp_f == `EXP_ALL_ONES);
        frac_nz = |frac_f;

        // all-ones exponent with any fraction bit set is a NaN
        is_nan  = exp_max & frac_nz;

        // the fraction msb is the quiet bit, so a NaN with it clear signals
        is_snan = is_nan & ~frac_f[`FRAC_W-1];

        // all-ones exponent with a clean fraction is an infinity
        is_inf  = exp_max & ~frac_nz;

        // either signed zero, denormals are not zero here
        is_zero = (op[`FP16_W-2:0] == '0);

        return {is_nan, is_snan, is_inf, is_zero, op[`FP16_W-1]};
    endfunction

    //////////////////////////////////////////////////////////////////////////
    // flag outputs
    //////////////////////////////////////////////////////////////////////////

    // each group is written by a single assignment so its five flags
    // always change together
    assign {cls.x_nan, cls.x_snan, cls.x_inf, cls.x_zero, cls.x_sign} = classify(x);
    assign {cls.y_nan, cls.y_snan, cls.y_inf, cls.y_zero, cls.y_sign} = classify(y);
    assign {cls.z_nan, cls.z_snan, cls.z_inf, cls.z_zero, cls.z_sign} = classify(z);

endmodule

/* special_case/special_case_resolver.sv */
/*
 * special-case resolver
 * picks the final FMA result from the operand flags, raises invalid and
 * reports whether a fixed special value replaced the rounded datapath result
 */

`timescale 1ns/100ps

`include "fma_special_macros.svh"

module special_case_resolver
(
    fp_class_if.dst                      cls,
    input  fma_special_pkg::fp16_t       z,
    input  fma_special_pkg::fp16_t       result_rounded,
    input  fma_special_pkg::round_mode_t roundmode,
    input  logic                         kill_z,
    input  logic                         kill_product,
    output fma_special_pkg::fp16_t       next_result,
    output logic                         next_invalid,
    output logic                         next_special
);

    import fma_special_pkg::*;

    // sign of x*y without any negated-product form
    logic         sign_product;
    logic         any_nan;
    logic         any_snan;
    // the product is infinite whenever either factor is
    logic         product_inf;
    logic         product_zero;
    logic         zero_times_inf;
    // inf + (-inf) in either direction
    logic         inf_cancel;
    // sign of an exact zero sum of the product and z
    logic         zero_neg;
    special_sel_t sel;

    //////////////////////////////////////////////////////////////////////////
    // priority resolution
    //////////////////////////////////////////////////////////////////////////

    // everything is derived inside one block so the select and the invalid
    // flag are always computed from the same snapshot of the flags
    always_comb
    begin
        sign_product   = cls.x_sign ^ cls.y_sign;
        any_nan        = cls.x_nan | cls.y_nan | cls.z_nan;
        any_snan       = cls.x_snan | cls.y_snan | cls.z_snan;
        product_inf    = cls.x_inf | cls.y_inf;
        product_zero   = cls.x_zero | cls.y_zero;
        zero_times_inf = (cls.x_zero & cls.y_inf) | (cls.y_zero & cls.x_inf);
        inf_cancel     = product_inf & cls.z_inf & (sign_product ^ cls.z_sign);

        // both addends negative give -0 and mixed signs give -0 only when
        // rounding toward negative infinity
        zero_neg = (sign_product & cls.z_sign)
                 | ((sign_product ^ cls.z_sign) & (roundmode == rm_down));

        // rule order matters since the first match wins
        if (any_nan)
        begin
            sel = sel_qnan;
        end
        else if (zero_times_inf)
        begin
            sel = sel_qnan;
        end
        else if (inf_cancel)
        begin
            sel = sel_qnan;
        end
        // an infinite product dominates any finite z
        else if (product_inf)
        begin
            sel = sign_product ? sel_neg_inf : sel_pos_inf;
        end
        else if (cls.z_inf)
        begin
            sel = cls.z_sign ? sel_neg_inf : sel_pos_inf;
        end
        else if (product_zero)
        begin
            // 0*y + 0 is an exact signed zero while 0*y + z is just z
            if (cls.z_zero)
            begin
                sel = zero_neg ? sel_neg_zero : sel_pos_zero;
            end
            else
            begin
                sel = sel_z;
            end
        end
        // alignment wiped out both terms so the sum is an exact zero
        else if (kill_z & kill_product)
        begin
            sel = zero_neg ? sel_neg_zero : sel_pos_zero;
        end
        else
        begin
            sel = sel_rounded;
        end

        // invalid covers 0*inf, inf-inf and any signalling NaN operand
        next_invalid = zero_times_inf | inf_cancel | any_snan;

        // an invalid operation can only ever produce the canonical NaN
        if (next_invalid)
        begin
            assert (sel == sel_qnan)
                else $error("invalid raised without a qNaN result");
        end

        // known flags and strobes must lead to a known selection
        if (!$isunknown({cls.x_nan, cls.y_nan, cls.z_nan, cls.x_inf, cls.y_inf,
                         cls.z_inf, cls.x_zero, cls.y_zero, cls.z_zero,
                         cls.x_sign, cls.y_sign, cls.z_sign,
                         kill_z, kill_product, roundmode}))
        begin
            assert (!$isunknown(sel))
                else $error("result select is unknown");
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // result mux
    //////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (sel)
            sel_z:        next_result = z;
            sel_qnan:     next_result = `FP16_QNAN;
            sel_pos_inf:  next_result = `FP16_POS_INF;
            sel_neg_inf:  next_result = `FP16_NEG_INF;
            sel_pos_zero: next_result = `FP16_POS_ZERO;
            sel_neg_zero: next_result = `FP16_NEG_ZERO;
            default:      next_result = result_rounded;
        endcase
    end

    // pass-through of z is an arithmetic outcome and not an override
    assign next_special = (sel != sel_rounded) && (sel != sel_z);

endmodule

/* src/fma_special_top.sv */
/*
 * binary16 FMA special-value stage
 * classifies the operands, resolves special cases and registers the outcome
 */

`timescale 1ns/100ps

`include "fma_special_macros.svh"

module fma_special_top
(
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         in_valid,
    input  fma_special_pkg::fp16_t       x,
    input  fma_special_pkg::fp16_t       y,
    input  fma_special_pkg::fp16_t       z,
    input  fma_special_pkg::round_mode_t roundmode,
    input  fma_special_pkg::fp16_t       result_rounded,
    input  logic                         kill_z,
    input  logic                         kill_product,
    output fma_special_pkg::fp16_t       result,
    output logic                         invalid,
    output logic                         special_case,
    output logic                         out_valid
);

    import fma_special_pkg::*;

    fp16_t next_result;
    logic  next_invalid;
    logic  next_special;

    // classification flags shared by the two combinational stages
    fp_class_if cls_if ();

    operand_classifier u_classifier
    (
        .x   (x),
        .y   (y),
        .z   (z),
        .cls (cls_if)
    );

    special_case_resolver u_resolver
    (
        .cls            (cls_if),
        .z              (z),
        .result_rounded (result_rounded),
        .roundmode      (roundmode),
        .kill_z         (kill_z),
        .kill_product   (kill_product),
        .next_result    (next_result),
        .next_invalid   (next_invalid),
        .next_special   (next_special)
    );

    //////////////////////////////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////////////////////////////

    // one-cycle stage, a new input may arrive every cycle
    // outputs hold their last value while in_valid stays low
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            out_valid    <= 1'b0;
            invalid      <= 1'b0;
            special_case <= 1'b0;
            result       <= `FP16_POS_ZERO;
        end
        else
        begin
            out_valid <= in_valid;
            if (in_valid)
            begin
                result       <= next_result;
                invalid      <= next_invalid;
                special_case <= next_special;
            end
        end
    end

    // out_valid only ever answers a strobe from the cycle before
    a_no_spurious_valid : assert property (
        @(posedge clk) disable iff (!arst_n)
        !in_valid |=> !out_valid
    ) else $error("out_valid raised without a preceding in_valid");

endmodule

/* dv/fma_special_tb.sv */
/*
 * testbench for the binary16 FMA special-value stage
 * directed and random rows from one table checked against a model of the rules
 */

`timescale 1ns/100ps

`include "fma_special_macros.svh"

module fma_special_tb;

    import fma_special_pkg::*;

    localparam int    CLK_PERIOD     = 20;
    localparam int    RESET_CYCLES   = 8;
    localparam int    TIMEOUT_CYCLES = 16;
    localparam int    RANDOM_ROWS    = 24;
    // stand-in for the upstream rounded sum that must never leak into a special result
    localparam fp16_t RND            = 16'h4D2B;

    // one stimulus row and the outcome it should produce
    typedef struct packed
    {
        fp16_t       x;
        fp16_t       y;
        fp16_t       z;
        round_mode_t rm;
        fp16_t       rr;
        logic [1:0]  kills;
        fp16_t       res;
        logic [1:0]  flags;
    } row_t;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    fp16_t       x;
    fp16_t       y;
    fp16_t       z;
    round_mode_t roundmode;
    fp16_t       result_rounded;
    logic        kill_z;
    logic        kill_product;
    fp16_t       result;
    logic        invalid;
    logic        special_case;
    logic        out_valid;
    row_t        rows[$];
    int          errors;
    int          checks;

    fma_special_top UUT
    (
        .clk            (clk),
        .arst_n         (arst_n),
        .in_valid       (in_valid),
        .x              (x),
        .y              (y),
        .z              (z),
        .roundmode      (roundmode),
        .result_rounded (result_rounded),
        .kill_z         (kill_z),
        .kill_product   (kill_product),
        .result         (result),
        .invalid        (invalid),
        .special_case   (special_case),
        .out_valid      (out_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////////

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // kills is {kill_z, kill_product} and flags is {invalid, special_case}
    task automatic add_row(input fp16_t a, input fp16_t b, input fp16_t c,
                           input round_mode_t rm, input fp16_t rr, input logic [1:0] kills,
                           input fp16_t res, input logic [1:0] flags);
        row_t r;
        r.x     = a;
        r.y     = b;
        r.z     = c;
        r.rm    = rm;
        r.rr    = rr;
        r.kills = kills;
        r.res   = res;
        r.flags = flags;
        rows.push_back(r);
    endtask

    function automatic logic is_nan(input fp16_t v);
        return (v[14:10] == 5'h1F) && (v[9:0] != 10'h0);
    endfunction

    // quiet bit is fraction bit 9
    function automatic logic is_snan(input fp16_t v);
        return is_nan(v) && !v[9];
    endfunction

    function automatic logic is_inf(input fp16_t v);
        return (v[14:10] == 5'h1F) && (v[9:0] == 10'h0);
    endfunction

    function automatic logic is_zero(input fp16_t v);
        return v[14:0] == 15'h0;
    endfunction

    // reference model of rules 1 to 7 that returns {result, invalid, special_case}
    function automatic logic [17:0] expected_outcome(input row_t r);
        logic ps;
        logic zero_inf;
        logic cancel;
        logic inv;
        logic neg0;
        ps       = r.x[15] ^ r.y[15];
        zero_inf = (is_zero(r.x) && is_inf(r.y)) || (is_inf(r.x) && is_zero(r.y));
        cancel   = (is_inf(r.x) || is_inf(r.y)) && is_inf(r.z) && (ps != r.z[15]);
        inv      = zero_inf || cancel || is_snan(r.x) || is_snan(r.y) || is_snan(r.z);
        // an exact zero is negative for two negative addends or for mixed signs in rm_down
        neg0     = (ps && r.z[15]) || ((ps != r.z[15]) && (r.rm == rm_down));
        if (is_nan(r.x) || is_nan(r.y) || is_nan(r.z) || zero_inf || cancel)
            return {16'h7E00, inv, 1'b1};
        if (is_inf(r.x) || is_inf(r.y))
            return {(ps ? 16'hFC00 : 16'h7C00), 2'b01};
        if (is_inf(r.z))
            return {(r.z[15] ? 16'hFC00 : 16'h7C00), 2'b01};
        if (is_zero(r.x) || is_zero(r.y))
            return is_zero(r.z) ? {(neg0 ? 16'h8000 : 16'h0000), 2'b01} : {r.z, 2'b00};
        if (r.kills == 2'b11)
            return {(neg0 ? 16'h8000 : 16'h0000), 2'b01};
        return {r.rr, 2'b00};
    endfunction

    // exponent kept away from 0 and 31 so the operand is a normal number
    function automatic fp16_t random_normal();
        logic [4:0] e;
        e = 5'(1 + ($urandom % 30));
        return {1'($urandom), e, 10'($urandom)};
    endfunction

    task automatic drive_row(input row_t r);
        x              = r.x;
        y              = r.y;
        z              = r.z;
        roundmode      = r.rm;
        result_rounded = r.rr;
        {kill_z, kill_product} = r.kills;
        in_valid       = 1'b1;
    endtask

    // strobe low with operands whose outcome differs from the held result
    task automatic drive_idle(input fp16_t held);
        in_valid       = 1'b0;
        x              = 16'h3C00;
        y              = 16'h3C00;
        z              = 16'h3C00;
        roundmode      = rm_nearest;
        result_rounded = ~held;
        {kill_z, kill_product} = 2'b00;
    endtask

    task automatic compare_outputs(input row_t r);
        check("result", 32'(result), 32'(r.res));
        check("invalid", 32'(invalid), 32'(r.flags[1]));
        check("special_case", 32'(special_case), 32'(r.flags[0]));
    endtask

    task automatic wait_out_valid(output int cycles);
        cycles = 0;
        while (!out_valid && cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////////

    initial
    begin
        int   cycles;
        int   directed;
        row_t r;

        void'($urandom(32'h9d5d));
        errors   = 0;
        checks   = 0;
        arst_n   = 1'b0;
        in_valid = 1'b0;
        x = '0;
        y = '0;
        z = '0;
        roundmode      = rm_nearest;
        result_rounded = '0;
        kill_z         = 1'b0;
        kill_product   = 1'b0;

        // NaN propagation, signalling NaNs and invalid operations
        add_row(16'h7E00, 16'h3C00, 16'h3C00, rm_nearest, RND, 2'b00, 16'h7E00, 2'b01);
        add_row(16'h3C00, 16'h4000, 16'hFE12, rm_nearest, RND, 2'b00, 16'h7E00, 2'b01);
        add_row(16'h7C01, 16'h3C00, 16'h3C00, rm_nearest, RND, 2'b00, 16'h7E00, 2'b11);
        add_row(16'h3C00, 16'h7D00, 16'h3C00, rm_nearest, RND, 2'b00, 16'h7E00, 2'b11);
        add_row(16'h3C00, 16'h3C00, 16'hFC20, rm_nearest, RND, 2'b00, 16'h7E00, 2'b11);
        add_row(16'h7E00, 16'h7C01, 16'h3C00, rm_nearest, RND, 2'b00, 16'h7E00, 2'b11);
        add_row(16'h0000, 16'h7C00, 16'h3C00, rm_nearest, RND, 2'b00, 16'h7E00, 2'b11);
        add_row(16'hFC00, 16'h8000, 16'h3C00, rm_nearest, RND, 2'b00, 16'h7E00, 2'b11);
        add_row(16'h7C00, 16'h3C00, 16'hFC00, rm_nearest, RND, 2'b00, 16'h7E00, 2'b11);
        // infinite product or infinite z where the latter even beats a zero product
        add_row(16'h7C00, 16'hC000, 16'h3C00, rm_nearest, RND, 2'b00, 16'hFC00, 2'b01);
        add_row(16'h7C00, 16'h3C00, 16'h7C00, rm_nearest, RND, 2'b00, 16'h7C00, 2'b01);
        add_row(16'h4000, 16'h4200, 16'hFC00, rm_nearest, RND, 2'b00, 16'hFC00, 2'b01);
        add_row(16'h0000, 16'h3C00, 16'h7C00, rm_nearest, RND, 2'b00, 16'h7C00, 2'b01);
        // zero products and fully cancelled sums
        add_row(16'h0000, 16'h8000, 16'h0000, rm_nearest, RND, 2'b00, 16'h0000, 2'b01);
        add_row(16'h0000, 16'h8000, 16'h0000, rm_down, RND, 2'b00, 16'h8000, 2'b01);
        add_row(16'h8000, 16'h8000, 16'h8000, rm_nearest, RND, 2'b00, 16'h0000, 2'b01);
        add_row(16'h8000, 16'h0000, 16'h8000, rm_nearest, RND, 2'b00, 16'h8000, 2'b01);
        add_row(16'h0000, 16'h4500, 16'hC123, rm_nearest, RND, 2'b00, 16'hC123, 2'b00);
        add_row(16'h3C00, 16'hBC00, 16'h3C00, rm_nearest, RND, 2'b11, 16'h0000, 2'b01);
        add_row(16'h3C00, 16'hBC00, 16'h3C00, rm_down, RND, 2'b11, 16'h8000, 2'b01);
        add_row(16'hBC00, 16'h3C00, 16'hBC00, rm_up, RND, 2'b11, 16'h8000, 2'b01);
        add_row(16'h3C00, 16'hBC00, 16'h3C00, rm_up, RND, 2'b11, 16'h0000, 2'b01);
        add_row(16'h3C00, 16'hBC00, 16'h3C00, rm_zero, RND, 2'b10, RND, 2'b00);
        add_row(16'h3C00, 16'h4000, 16'h4200, rm_nearest, 16'h4400, 2'b00, 16'h4400, 2'b00);
        directed = rows.size();

        // random normal operands with expected values from the model
        for (int i = 0; i < RANDOM_ROWS; i++)
        begin
            r.x     = random_normal();
            r.y     = random_normal();
            r.z     = random_normal();
            r.rm    = round_mode_t'(2'($urandom));
            r.rr    = 16'($urandom);
            r.kills = {1'($urandom), 1'b0};
            {r.res, r.flags} = expected_outcome(r);
            rows.push_back(r);
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        arst_n = 1'b1;

        // idle outputs straight after reset and before any clock edge
        #1;
        check("out_valid", 32'(out_valid), 32'd0);
        check("invalid", 32'(invalid), 32'd0);
        check("special_case", 32'(special_case), 32'd0);
        check("result", 32'(result), 32'h0);
        @(posedge clk);
        #2;

        // directed rows one at a time with an idle cycle to check the hold
        for (int i = 0; i < directed; i++)
        begin
            drive_row(rows[i]);
            wait_out_valid(cycles);
            #1;
            drive_idle(rows[i].res);
            if (!out_valid)
            begin
                errors++;
                $display("timeout waiting for out_valid on row %0d", i);
            end
            check("latency", 32'(cycles), 32'd1);
            compare_outputs(rows[i]);
            @(posedge clk);
            #1;
            check("out_valid", 32'(out_valid), 32'd0);
            compare_outputs(rows[i]);
            #1;
        end

        // random rows back to back so each is answered on the very next cycle
        drive_row(rows[directed]);
        for (int i = directed; i < rows.size(); i++)
        begin
            @(posedge clk);
            #1;
            check("out_valid", 32'(out_valid), 32'd1);
            compare_outputs(rows[i]);
            #1;
            if (i + 1 < rows.size())
                drive_row(rows[i + 1]);
            else
                drive_idle(rows[i].res);
        end
        @(posedge clk);
        #1;
        check("out_valid", 32'(out_valid), 32'd0);
        compare_outputs(rows[rows.size() - 1]);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

/* build.f */
+incdir+common
common/fma_special_pkg.sv
common/fp_class_if.sv
special_case/operand_classifier.sv
special_case/special_case_resolver.sv
src/fma_special_top.sv
dv/fma_special_tb.sv

/* Makefile */
# Verilator simulation of the binary16 FMA special-value stage

TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = fma_special_tb
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = All tests passed

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
